//--- turret_top.f
+incdir+.
pixel_pkg.sv
track_pkg.sv
serial_divider.sv
track_timer.sv
frame_capture.sv
centroid_accum.sv
target_tracker.sv
turret_top.sv
turret_sva.sv
turret_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the turret testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert -j 0 -f turret_top.f --top-module turret_tb -o turret_sim
./obj_dir/turret_sim | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- turret_tb.sv
/*
 * Testbench for the turret tracking path: table-driven sensor frames,
 * aim, lock, fire and frame count checks, watchdog and summary
 */
`timescale 1ns/1ps
`default_nettype none
`include "tracker_settings.svh"

module tb_clock #(
    parameter int PERIOD_NS = 200
) (
    output logic d5m_pixlclk
);

    initial
    begin
        d5m_pixlclk = 1'b0;
        forever #(PERIOD_NS / 2) d5m_pixlclk = ~d5m_pixlclk;
    end

endmodule

module turret_tb;

    localparam int ACT_NONE    = 0;
    localparam int ACT_START   = 1;
    localparam int ACT_STOP    = 2;
    localparam int HBLANK      = 4;
    localparam int PRE_IDLE    = 4;
    localparam int ACK_TIMEOUT = 200;
    localparam int NSTEP       = 8;

    typedef struct packed {
        int act;
        int w, h;
        int x0, x1, y0, y1, lvl;
        int gap;
        int ex, ey, lk, fr, fc;
    } step_t;

    logic                d5m_pixlclk;
    logic                rst_n;
    pixel_pkg::pix_t     d5m_d;
    logic                d5m_fval;
    logic                d5m_lval;
    logic                capture_start;
    logic                capture_stop;
    pixel_pkg::col_t     aim_x;
    pixel_pkg::row_t     aim_y;
    logic                fire;
    logic                locked;
    pixel_pkg::frame_t   frame_count;

    logic [31:0] rng_state = 32'h9ec09142;
    int          errors = 0;
    int          tests = 0;
    int          failed = 0;
    int          fire_cycles = 0;

    // act, w, h, box x0 x1 y0 y1, level, gap, aim x y, locked, fire, frames
    step_t steps [NSTEP] = '{
        '{ACT_START, 28, 8,  4,  7, 1, 4, 4000,   40,   5,   2, 1, 0, 1},
        '{ACT_NONE,  28, 8,  8, 11, 2, 5, 2500,   40,   5,   2, 1, 0, 2},
        '{ACT_NONE,  28, 8, 10, 12, 3, 3, 4000,   40,   5,   2, 1, 0, 3},
        '{ACT_NONE,  28, 8,  6,  9, 2, 5, 4000,   40,   7,   3, 1, 1, 4},
        '{ACT_NONE,  28, 8, 20, 25, 4, 6, 4000,   40,  22,   5, 1, 0, 5},
        '{ACT_STOP,  28, 8,  2,  5, 1, 3, 4000,   40,  22,   5, 1, 0, 5},
        '{ACT_START, 28, 8,  2,  5, 0, 3, 4000,   40,   3,   1, 1, 0, 6},
        '{ACT_NONE,  28, 8,  0,  0, 0, 0,    0, 2600, 320, 240, 0, 0, 7}
    };
    string names [NSTEP] = '{"first_lock", "dim_box", "tiny_box", "near_fire",
                             "far_move", "stopped", "restarted", "hold_lost"};

    tb_clock #(.PERIOD_NS(200)) u_clock (.d5m_pixlclk(d5m_pixlclk));

    turret_top turret_top_inst (
        .d5m_pixlclk   (d5m_pixlclk),
        .rst_n         (rst_n),
        .d5m_d         (d5m_d),
        .d5m_fval      (d5m_fval),
        .d5m_lval      (d5m_lval),
        .capture_start (capture_start),
        .capture_stop  (capture_stop),
        .aim_x         (aim_x),
        .aim_y         (aim_y),
        .fire          (fire),
        .locked        (locked),
        .frame_count   (frame_count)
    );

    // Length of each fire burst
    always @(negedge d5m_pixlclk)
    begin
        if (fire)
            fire_cycles <= fire_cycles + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    task automatic check_value(input string test, input string what,
                               input int expv, input int actv);
        assert (expv == actv)
        else
        begin
            $display("FAILED %s %s expected %0d actual %0d", test, what, expv, actv);
            errors++;
        end
    endtask

    task automatic report_test(input string test, input int errs_before);
        tests++;
        if (errors == errs_before)
            $display("PASS %s", test);
        else
        begin
            $display("FAIL %s", test);
            failed++;
        end
    endtask

    // ======================================================================
    // Sensor frame with h lines of w pixels and blanking inside fval
    // ======================================================================
    task automatic drive_frame(input step_t s);
        int x;
        int y;
        @(posedge d5m_pixlclk);
        d5m_fval <= 1'b1;
        for (y = 0; y < s.h; y++)
        begin
            for (x = 0; x < s.w + HBLANK; x++)
            begin
                @(posedge d5m_pixlclk);
                d5m_lval <= (x < s.w);
                rng_state = xorshift32(rng_state);
                if (x >= s.x0 && x <= s.x1 && y >= s.y0 && y <= s.y1)
                    d5m_d <= pixel_pkg::pix_t'(s.lvl);
                else
                    d5m_d <= pixel_pkg::pix_t'(rng_state % `TRK_THRESHOLD);
            end
        end
        @(posedge d5m_pixlclk);
        d5m_fval <= 1'b0;
    endtask

    task automatic wait_handshake(input string test);
        int waited;
        waited = 0;
        while (!turret_top_inst.cent_ack && waited < ACK_TIMEOUT)
        begin
            @(negedge d5m_pixlclk);
            waited++;
        end
        assert (turret_top_inst.cent_ack)
        else
        begin
            $display("%s: the tracker never acknowledged a centroid", test);
            errors++;
        end
    endtask

    initial
    begin : stimulus
        step_t s;
        int    errs_before;
        int    fires_before;
        bit    cap_on;
        bit    upd;
        d5m_d         <= '0;
        d5m_fval      <= 1'b0;
        d5m_lval      <= 1'b0;
        capture_start <= 1'b0;
        capture_stop  <= 1'b0;
        rst_n         <= 1'b0;
        cap_on = 1'b0;
        repeat (2) @(posedge d5m_pixlclk);
        rst_n <= 1'b1;
        @(negedge d5m_pixlclk);
        errs_before = errors;
        check_value("reset", "aim_x", `TRK_CENTER_X, int'(aim_x));
        check_value("reset", "aim_y", `TRK_CENTER_Y, int'(aim_y));
        check_value("reset", "fire", 0, int'(fire));
        check_value("reset", "locked", 0, int'(locked));
        check_value("reset", "frame_count", 0, int'(frame_count));
        report_test("reset", errs_before);

        foreach (steps[i])
        begin
            s = steps[i];
            errs_before = errors;
            fires_before = fire_cycles;
            if (s.act == ACT_START)
                cap_on = 1'b1;
            else if (s.act == ACT_STOP)
                cap_on = 1'b0;
            // A centroid only comes from a captured, bright, large enough box
            upd = cap_on && (s.lvl > `TRK_THRESHOLD) &&
                  ((s.x1 - s.x0 + 1) * (s.y1 - s.y0 + 1) >= `TRK_MIN_PIXELS);
            @(posedge d5m_pixlclk);
            capture_start <= (s.act == ACT_START);
            capture_stop  <= (s.act == ACT_STOP);
            @(posedge d5m_pixlclk);
            capture_start <= 1'b0;
            capture_stop  <= 1'b0;
            repeat (PRE_IDLE) @(posedge d5m_pixlclk);
            drive_frame(s);
            if (upd)
                wait_handshake(names[i]);
            repeat (s.gap) @(posedge d5m_pixlclk);
            @(negedge d5m_pixlclk);
            check_value(names[i], "aim_x", s.ex, int'(aim_x));
            check_value(names[i], "aim_y", s.ey, int'(aim_y));
            check_value(names[i], "locked", s.lk, int'(locked));
            check_value(names[i], "frame_count", s.fc, int'(frame_count));
            check_value(names[i], "fire cycles", s.fr * `TRK_FIRE_CYCLES,
                        fire_cycles - fires_before);
            report_test(names[i], errs_before);
        end

        $display("Tests run %0d, failed %0d, check errors %0d", tests, failed, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    // ======================================================================
    // Watchdog over twice the frame and gap time plus margin
    // ======================================================================
    initial
    begin : watchdog
        int limit;
        limit = 0;
        foreach (steps[i])
            limit += steps[i].h * (steps[i].w + HBLANK) + PRE_IDLE + 4 + steps[i].gap;
        repeat (limit * 2 + 1000) @(posedge d5m_pixlclk);
        $display("Timeout: the run did not finish within %0d cycles", limit * 2 + 1000);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- turret_sva.sv
/*
 * Assertions on the centroid handshake and tracker outputs
 */
`timescale 1ns/1ps
`default_nettype none

module turret_sva (
    input wire                  d5m_pixlclk,
    input wire                  rst_n,
    input wire                  cent_req,
    input wire                  cent_ack,
    input wire pixel_pkg::col_t cent_x,
    input wire pixel_pkg::row_t cent_y,
    input wire                  fire,
    input wire                  locked
);

    // Centroid held while the request is open
    a_cent_stable: assert property (@(posedge d5m_pixlclk) disable iff (!rst_n)
        cent_req |=> !cent_req || ($stable(cent_x) && $stable(cent_y)))
    else $error("centroid changed while cent_req was high");

    a_req_held: assert property (@(posedge d5m_pixlclk) disable iff (!rst_n)
        cent_req && !cent_ack |=> cent_req)
    else $error("cent_req dropped before cent_ack");

    // Ack released only after req falls
    a_ack_order: assert property (@(posedge d5m_pixlclk) disable iff (!rst_n)
        cent_ack && cent_req |=> cent_ack)
    else $error("cent_ack dropped while cent_req was still high");

    // Lock survives the end of a burst
    a_fire_locked: assert property (@(posedge d5m_pixlclk) disable iff (!rst_n)
        fire |=> locked)
    else $error("locked dropped right after fire");

endmodule

bind target_tracker turret_sva turret_sva_inst (
    .d5m_pixlclk (d5m_pixlclk),
    .rst_n       (rst_n),
    .cent_req    (cent_req),
    .cent_ack    (cent_ack),
    .cent_x      (cent_x),
    .cent_y      (cent_y),
    .fire        (fire),
    .locked      (locked)
);

`default_nettype wire

//--- turret_top.sv
/*
 * Turret tracking path: capture, centroid and tracker on the pixel clock
 */
`timescale 1ns/1ps
`default_nettype none

module turret_top (
    input  wire                    d5m_pixlclk,
    input  wire                    rst_n,
    input  wire pixel_pkg::pix_t   d5m_d,
    input  wire                    d5m_fval,
    input  wire                    d5m_lval,
    input  wire                    capture_start,
    input  wire                    capture_stop,
    output pixel_pkg::col_t        aim_x,
    output pixel_pkg::row_t        aim_y,
    output logic                   fire,
    output logic                   locked,
    output pixel_pkg::frame_t      frame_count
);

    logic            pix_valid;
    pixel_pkg::pix_t pix;
    pixel_pkg::col_t col;
    pixel_pkg::row_t row;
    logic            frame_done;
    logic            cent_req;
    logic            cent_ack;
    pixel_pkg::col_t cent_x;
    pixel_pkg::row_t cent_y;

    frame_capture u_capture (
        .d5m_pixlclk   (d5m_pixlclk),
        .rst_n         (rst_n),
        .d5m_d         (d5m_d),
        .d5m_fval      (d5m_fval),
        .d5m_lval      (d5m_lval),
        .capture_start (capture_start),
        .capture_stop  (capture_stop),
        .pix_valid     (pix_valid),
        .pix           (pix),
        .col           (col),
        .row           (row),
        .frame_done    (frame_done),
        .frame_count   (frame_count)
    );

    centroid_accum u_centroid (
        .d5m_pixlclk (d5m_pixlclk),
        .rst_n       (rst_n),
        .pix_valid   (pix_valid),
        .pix         (pix),
        .col         (col),
        .row         (row),
        .frame_done  (frame_done),
        .cent_req    (cent_req),
        .cent_ack    (cent_ack),
        .cent_x      (cent_x),
        .cent_y      (cent_y)
    );

    target_tracker u_tracker (
        .d5m_pixlclk (d5m_pixlclk),
        .rst_n       (rst_n),
        .cent_req    (cent_req),
        .cent_ack    (cent_ack),
        .cent_x      (cent_x),
        .cent_y      (cent_y),
        .aim_x       (aim_x),
        .aim_y       (aim_y),
        .fire        (fire),
        .locked      (locked)
    );

endmodule

`default_nettype wire

//--- target_tracker.sv
/*
 * Target tracker FSM: takes centroids over req/ack, keeps the aim
 * point and raises the fire pulse when the target holds still
 */
`timescale 1ns/1ps
`default_nettype none
`include "tracker_settings.svh"

module target_tracker (
    input  wire                    d5m_pixlclk,
    input  wire                    rst_n,
    input  wire                    cent_req,
    output logic                   cent_ack,
    input  wire pixel_pkg::col_t   cent_x,
    input  wire pixel_pkg::row_t   cent_y,
    output pixel_pkg::col_t        aim_x,
    output pixel_pkg::row_t        aim_y,
    output logic                   fire,
    output logic                   locked
);

    track_pkg::track_state_t state;
    track_pkg::track_state_t state_nxt;
    track_pkg::timer_sel_t   timer_sel;
    logic                    timer_start;
    logic                    expired;
    logic                    take;
    logic                    near_aim;
    pixel_pkg::col_t         dx;
    pixel_pkg::row_t         dy;

    // No new centroid accepted while firing
    assign take = cent_req && !cent_ack && (state != track_pkg::FIRE);

    assign dx = (cent_x >= aim_x) ? cent_x - aim_x : aim_x - cent_x;
    assign dy = (cent_y >= aim_y) ? cent_y - aim_y : aim_y - cent_y;
    assign near_aim = (dx <= pixel_pkg::col_t'(`TRK_AIM_WINDOW)) &&
                      (dy <= pixel_pkg::row_t'(`TRK_AIM_WINDOW));

    // =====================================================================
    // Next state and timer control
    // =====================================================================
    always_comb
    begin
        state_nxt   = state;
        timer_start = 1'b0;
        timer_sel   = track_pkg::TMR_HOLD;
        case (state)
            track_pkg::SEARCH:
            begin
                if (take)
                begin
                    state_nxt   = track_pkg::TRACK;
                    timer_start = 1'b1;
                end
            end
            track_pkg::TRACK:
            begin
                if (take)
                begin
                    timer_start = 1'b1;
                    if (near_aim)
                    begin
                        state_nxt = track_pkg::FIRE;
                        timer_sel = track_pkg::TMR_FIRE;
                    end
                end
                else if (expired)
                    state_nxt = track_pkg::SEARCH;
            end
            track_pkg::FIRE:
            begin
                // Fresh hold once the burst is over
                if (expired)
                begin
                    state_nxt   = track_pkg::TRACK;
                    timer_start = 1'b1;
                end
            end
            default: state_nxt = track_pkg::SEARCH;
        endcase
    end

    always_ff @(posedge d5m_pixlclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= track_pkg::SEARCH;
            cent_ack <= 1'b0;
            aim_x    <= pixel_pkg::col_t'(`TRK_CENTER_X);
            aim_y    <= pixel_pkg::row_t'(`TRK_CENTER_Y);
        end
        else
        begin
            state <= state_nxt;

            if (take)
                cent_ack <= 1'b1;
            else if (!cent_req)
                cent_ack <= 1'b0;

            if (take)
            begin
                aim_x <= cent_x;
                aim_y <= cent_y;
            end
            else if (state_nxt == track_pkg::SEARCH)
            begin
                aim_x <= pixel_pkg::col_t'(`TRK_CENTER_X);
                aim_y <= pixel_pkg::row_t'(`TRK_CENTER_Y);
            end
        end
    end

    assign fire   = (state == track_pkg::FIRE);
    assign locked = (state != track_pkg::SEARCH);

    track_timer u_timer (
        .d5m_pixlclk (d5m_pixlclk),
        .rst_n       (rst_n),
        .timer_start (timer_start),
        .timer_sel   (timer_sel),
        .expired     (expired)
    );

endmodule

`default_nettype wire

//--- centroid_accum.sv
/*
 * Centroid unit: sums object pixel positions per frame, divides by
 * the pixel count and offers the mean over a req/ack handshake
 */
`timescale 1ns/1ps
`default_nettype none
`include "tracker_settings.svh"

module centroid_accum (
    input  wire                    d5m_pixlclk,
    input  wire                    rst_n,
    input  wire                    pix_valid,
    input  wire pixel_pkg::pix_t   pix,
    input  wire pixel_pkg::col_t   col,
    input  wire pixel_pkg::row_t   row,
    input  wire                    frame_done,
    output logic                   cent_req,
    input  wire                    cent_ack,
    output pixel_pkg::col_t        cent_x,
    output pixel_pkg::row_t        cent_y
);

    pixel_pkg::sum_t sum_x;
    pixel_pkg::sum_t sum_y;
    pixel_pkg::sum_t obj_cnt;
    logic            obj_pix;
    logic            busy;
    logic            div_start;
    logic            div_busy;
    logic            done_x;
    logic            done_y;
    logic            done_x_seen;
    logic            done_y_seen;
    logic            both_done;

    assign obj_pix = pix_valid && (pix > pixel_pkg::pix_t'(`TRK_THRESHOLD));

    // Open handshake or pending division blocks the next frame
    assign busy      = div_busy || cent_req || cent_ack;
    assign div_start = frame_done && !busy &&
                       (obj_cnt >= pixel_pkg::sum_t'(`TRK_MIN_PIXELS));
    assign both_done = (done_x || done_x_seen) && (done_y || done_y_seen);

    // =====================================================================
    // Per-frame sums
    // =====================================================================
    always_ff @(posedge d5m_pixlclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sum_x   <= '0;
            sum_y   <= '0;
            obj_cnt <= '0;
        end
        else if (frame_done)
        begin
            sum_x   <= '0;
            sum_y   <= '0;
            obj_cnt <= '0;
        end
        else if (obj_pix)
        begin
            sum_x   <= sum_x + pixel_pkg::sum_t'(col);
            sum_y   <= sum_y + pixel_pkg::sum_t'(row);
            obj_cnt <= obj_cnt + 1'b1;
        end
    end

    // =====================================================================
    // Division tracking and request side of the handshake
    // =====================================================================
    always_ff @(posedge d5m_pixlclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            div_busy    <= 1'b0;
            done_x_seen <= 1'b0;
            done_y_seen <= 1'b0;
            cent_req    <= 1'b0;
        end
        else
        begin
            if (div_start)
            begin
                div_busy    <= 1'b1;
                done_x_seen <= 1'b0;
                done_y_seen <= 1'b0;
            end
            else if (div_busy && both_done)
            begin
                div_busy    <= 1'b0;
                done_x_seen <= 1'b0;
                done_y_seen <= 1'b0;
                cent_req    <= 1'b1;
            end
            else
            begin
                done_x_seen <= done_x_seen || done_x;
                done_y_seen <= done_y_seen || done_y;
            end

            if (cent_req && cent_ack)
                cent_req <= 1'b0;
        end
    end

    serial_divider #(.quot_t(pixel_pkg::col_t)) u_div_x (
        .d5m_pixlclk (d5m_pixlclk),
        .rst_n       (rst_n),
        .start       (div_start),
        .dividend    (sum_x),
        .divisor     (obj_cnt),
        .done        (done_x),
        .quotient    (cent_x)
    );

    serial_divider #(.quot_t(pixel_pkg::row_t)) u_div_y (
        .d5m_pixlclk (d5m_pixlclk),
        .rst_n       (rst_n),
        .start       (div_start),
        .dividend    (sum_y),
        .divisor     (obj_cnt),
        .done        (done_y),
        .quotient    (cent_y)
    );

endmodule

`default_nettype wire

//--- frame_capture.sv
/*
 * Sensor front end: registers the D5M bus, gates capture per frame,
 * counts column, row and captured frames
 */
`timescale 1ns/1ps
`default_nettype none

module frame_capture (
    input  wire                    d5m_pixlclk,
    input  wire                    rst_n,
    input  wire pixel_pkg::pix_t   d5m_d,
    input  wire                    d5m_fval,
    input  wire                    d5m_lval,
    input  wire                    capture_start,
    input  wire                    capture_stop,
    output logic                   pix_valid,
    output pixel_pkg::pix_t        pix,
    output pixel_pkg::col_t        col,
    output pixel_pkg::row_t        row,
    output logic                   frame_done,
    output pixel_pkg::frame_t      frame_count
);

    pixel_pkg::pix_t r_d;
    logic            r_fval;
    logic            r_lval;
    logic            fval_q;
    logic            lval_q;
    logic            start_q;
    logic            stop_q;
    logic            run;
    logic            capturing;
    pixel_pkg::col_t x_cnt;
    pixel_pkg::row_t y_cnt;

    // Sensor data register
    always_ff @(posedge d5m_pixlclk)
    begin
        r_d <= d5m_d;
    end

    always_ff @(posedge d5m_pixlclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            r_fval      <= 1'b0;
            r_lval      <= 1'b0;
            fval_q      <= 1'b0;
            lval_q      <= 1'b0;
            start_q     <= 1'b0;
            stop_q      <= 1'b0;
            run         <= 1'b0;
            capturing   <= 1'b0;
            x_cnt       <= '0;
            y_cnt       <= '0;
            frame_done  <= 1'b0;
            frame_count <= '0;
        end
        else
        begin
            r_fval  <= d5m_fval;
            r_lval  <= d5m_lval;
            fval_q  <= r_fval;
            lval_q  <= r_lval;
            start_q <= capture_start;
            stop_q  <= capture_stop;

            if (start_q)
                run <= 1'b1;
            else if (stop_q)
                run <= 1'b0;

            // Run flag only takes effect at frame start
            if (d5m_fval && !r_fval)
                capturing <= run;

            if (!r_lval)
                x_cnt <= '0;
            else
                x_cnt <= x_cnt + 1'b1;

            if (!r_fval)
                y_cnt <= '0;
            else if (lval_q && !r_lval)
                y_cnt <= y_cnt + 1'b1;

            frame_done <= fval_q && !r_fval && capturing;
            if (fval_q && !r_fval && capturing)
                frame_count <= frame_count + 1'b1;
        end
    end

    assign pix_valid = r_fval && r_lval && capturing;
    assign pix       = r_d;
    assign col       = x_cnt;
    assign row       = y_cnt;

endmodule

`default_nettype wire

//--- track_timer.sv
/*
 * Interval timer for the tracker, hold or fire length, restartable
 */
`timescale 1ns/1ps
`default_nettype none
`include "tracker_settings.svh"

module track_timer (
    input  wire                        d5m_pixlclk,
    input  wire                        rst_n,
    input  wire                        timer_start,
    input  wire track_pkg::timer_sel_t timer_sel,
    output logic                       expired
);

    // Hold is the longer interval
    localparam int CNT_W = $clog2(`TRK_HOLD_CYCLES);

    logic [CNT_W-1:0] count;
    logic             running;

    always_ff @(posedge d5m_pixlclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count   <= '0;
            running <= 1'b0;
        end
        else if (timer_start)
        begin
            running <= 1'b1;
            if (timer_sel == track_pkg::TMR_FIRE)
                count <= CNT_W'(`TRK_FIRE_CYCLES - 1);
            else
                count <= CNT_W'(`TRK_HOLD_CYCLES - 1);
        end
        else if (running)
        begin
            if (count == '0)
                running <= 1'b0;
            else
                count <= count - 1'b1;
        end
    end

    assign expired = running && (count == '0);

endmodule

`default_nettype wire

//--- serial_divider.sv
/*
 * Restoring divider, one quotient bit per clock, quotient width
 * taken from the quot_t type
 */
`timescale 1ns/1ps
`default_nettype none

module serial_divider #(
    parameter type quot_t = pixel_pkg::col_t
) (
    input  wire                    d5m_pixlclk,
    input  wire                    rst_n,
    input  wire                    start,
    input  wire pixel_pkg::sum_t   dividend,
    input  wire pixel_pkg::sum_t   divisor,
    output logic                   done,
    output quot_t                  quotient
);

    localparam int QW = $bits(quot_t);
    localparam int SW = $bits(pixel_pkg::sum_t);
    localparam int CW = $clog2(QW + 1);

    logic [SW+QW-1:0] rem_w;
    logic [SW+QW-1:0] dvs_w;
    logic [SW+QW-1:0] diff_w;
    logic [QW-1:0]    quot_q;
    logic [CW-1:0]    bits_left;
    logic             running;
    logic             fits;

    assign fits   = (rem_w >= dvs_w);
    assign diff_w = rem_w - dvs_w;

    always_ff @(posedge d5m_pixlclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            running   <= 1'b0;
            bits_left <= '0;
            done      <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                running   <= 1'b1;
                bits_left <= CW'(QW);
            end
            else if (running)
            begin
                bits_left <= bits_left - 1'b1;
                if (bits_left == CW'(1))
                begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // Divisor starts aligned to the top quotient bit
    always_ff @(posedge d5m_pixlclk)
    begin
        if (start)
        begin
            rem_w <= {{QW{1'b0}}, dividend};
            dvs_w <= {{QW{1'b0}}, divisor} << (QW - 1);
        end
        else if (running)
        begin
            if (fits)
                rem_w <= diff_w;
            dvs_w  <= dvs_w >> 1;
            quot_q <= {quot_q[QW-2:0], fits};
        end
    end

    assign quotient = quot_q;

endmodule

`default_nettype wire

//--- track_pkg.sv
/*
 * Tracker control types: FSM states and timer interval select
 */
`default_nettype none

package track_pkg;

    typedef enum logic [1:0] {
        SEARCH = 2'd0,
        TRACK  = 2'd1,
        FIRE   = 2'd2
    } track_state_t;

    typedef enum logic {
        TMR_HOLD = 1'b0,
        TMR_FIRE = 1'b1
    } timer_sel_t;

endpackage

`default_nettype wire

//--- pixel_pkg.sv
/*
 * Pixel path types: raw samples, positions, sums and frame numbers
 */
`default_nettype none
`include "tracker_settings.svh"

package pixel_pkg;

    // Raw sensor sample
    typedef logic [`TRK_PIX_W-1:0]   pix_t;

    // Position inside the frame
    typedef logic [`TRK_X_W-1:0]     col_t;
    typedef logic [`TRK_Y_W-1:0]     row_t;

    // Running sums and pixel counts
    typedef logic [`TRK_SUM_W-1:0]   sum_t;

    typedef logic [`TRK_FRAME_W-1:0] frame_t;

endpackage

`default_nettype wire

//--- tracker_settings.svh
/*
 * Turret tracker constants: data widths, object threshold,
 * hold and fire intervals, and the rest aim point
 */
`ifndef TRACKER_SETTINGS_SVH
`define TRACKER_SETTINGS_SVH

// Sensor and position widths
`define TRK_PIX_W        12
`define TRK_X_W          10
`define TRK_Y_W          9
`define TRK_FRAME_W      24
`define TRK_SUM_W        32

// Object detection
`define TRK_THRESHOLD    3000
`define TRK_MIN_PIXELS   4
`define TRK_AIM_WINDOW   8

// Tracker intervals in pixel clocks
`define TRK_HOLD_CYCLES  2000
`define TRK_FIRE_CYCLES  16

// Rest aim at the middle of a 640x480 view
`define TRK_CENTER_X     320
`define TRK_CENTER_Y     240

`endif
